// ==== verilog/helm_pkg.sv ====
package helm_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int BUF_AW = 11;
    localparam int CNT_W  = 11;

    // byte offsets from the first byte of the ethernet frame
    localparam int OFS_ETYPE_HI    = 12;
    localparam int OFS_ETYPE_LO    = 13;
    localparam int OFS_PROTO       = 23;
    localparam int OFS_DST_IP      = 30;
    localparam int OFS_DST_PORT    = 36;
    localparam int OFS_UDP_LEN     = 38;
    localparam int OFS_UDP_PAYLOAD = 41;
    localparam int OFS_PREAMBLE    = 42;
    localparam int OFS_MSG_TYPE    = 46;
    localparam int OFS_SEQ         = 47;
    localparam int OFS_LEN         = 48;
    localparam int OFS_BODY        = 49;

    // ------------------------------
    // protocol constants
    // ------------------------------
    localparam logic [7:0] ETYPE_IPV4_HI = 8'h08;
    localparam logic [7:0] ETYPE_IPV4_LO = 8'h00;
    localparam logic [7:0] PROTO_UDP     = 8'h11;
    localparam int         UDP_HDR_LEN   = 8;

    localparam logic [7:0] PREAMBLE_3 = 8'haa;
    localparam logic [7:0] PREAMBLE_2 = 8'h99;
    localparam logic [7:0] PREAMBLE_1 = 8'h55;
    localparam logic [7:0] PREAMBLE_0 = 8'h66;

    localparam logic [7:0] MSG_BLK_WRITE  = 8'h00;
    localparam logic [7:0] MSG_BYTE_WRITE = 8'h01;

    // receive FSM encoding
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_RECV = 3'd1;
    localparam logic [2:0] ST_DROP = 3'd2;
    localparam logic [2:0] ST_DONE = 3'd3;
    localparam logic [2:0] ST_EXEC = 3'd4;

    // ------------------------------
    // types
    // ------------------------------
    typedef struct packed {
        logic       valid;
        logic       sof;
        logic       eof;
        logic [7:0] data;
    } mac_rx_t;

    typedef struct packed {
        logic       cs;
        logic       rd_en;
        logic       wr_en;
        logic [7:0] page;
        logic [7:0] offset;
        logic [7:0] wr_data;
    } usr_mem_req_t;

    // total_len counts body bytes, checksum byte not included
    typedef struct packed {
        logic [7:0] msg_type;
        logic [7:0] seq_no;
        logic [7:0] total_len;
    } msg_hdr_t;

    typedef struct packed {
        logic [7:0] page;
        logic [7:0] offset;
        logic [7:0] data_len;
        logic [7:0] first_data;
    } blk_cmd_t;

    typedef struct packed {
        logic [7:0] page;
        logic [7:0] offset;
        logic [7:0] value;
        logic [7:0] mask;
    } byte_cmd_t;

    // first four body bytes, byte 0 in the top lane
    typedef union packed {
        blk_cmd_t  blk;
        byte_cmd_t byt;
    } cmd_word_u;

endpackage

// ==== verilog/helm_byte_counter.sv ====
module helm_byte_counter
    import helm_pkg::*;
(
    input  logic             clk,
    input  logic             rst_b,
    input  mac_rx_t          mac_rx,
    output logic [CNT_W-1:0] byte_idx
);

    // index of the beat on the bus, zero again after eof
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            byte_idx <= '0;
        end else if (mac_rx.valid) begin
            if (mac_rx.eof) begin
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/helm_frame_check.sv ====
module helm_frame_check
    import helm_pkg::*;
(
    input  logic             clk,
    input  logic             rst_b,
    input  mac_rx_t          mac_rx,
    input  logic [CNT_W-1:0] byte_idx,
    input  logic [31:0]      listened_ip1,
    input  logic [31:0]      listened_ip2,
    input  logic [15:0]      listened_port,
    output logic             hdr_fail,
    output logic             msg_ok,
    output msg_hdr_t         hdr,
    output logic             body_wr,
    output logic [7:0]       body_data
);

    logic [23:0] dst_ip_hi;
    logic [7:0]  dst_port_hi;
    logic [15:0] udp_len;
    logic [15:0] payload_len;
    logic [15:0] pay_idx;
    logic [7:0]  csum;
    logic        fail_now;
    logic        in_body;
    logic        last_pay;
    logic        len_match;

    assign payload_len = udp_len - 16'(UDP_HDR_LEN);
    // 1-based position inside the udp payload
    assign pay_idx     = 16'(byte_idx) - 16'(OFS_UDP_PAYLOAD);
    assign in_body     = (byte_idx >= CNT_W'(OFS_BODY)) && (pay_idx <= payload_len);
    assign last_pay    = in_body && (pay_idx == payload_len);
    assign len_match   = (byte_idx - CNT_W'(OFS_BODY)) == CNT_W'(hdr.total_len);

    // ------------------------------
    // fixed field compare
    // ------------------------------
    always_comb begin
        fail_now = 1'b0;
        case (byte_idx)
            CNT_W'(OFS_ETYPE_HI):     fail_now = (mac_rx.data != ETYPE_IPV4_HI);
            CNT_W'(OFS_ETYPE_LO):     fail_now = (mac_rx.data != ETYPE_IPV4_LO);
            CNT_W'(OFS_PROTO):        fail_now = (mac_rx.data != PROTO_UDP);
            CNT_W'(OFS_DST_IP + 3):   fail_now = ({dst_ip_hi, mac_rx.data} != listened_ip1) &&
                                                 ({dst_ip_hi, mac_rx.data} != listened_ip2);
            CNT_W'(OFS_DST_PORT + 1): fail_now = ({dst_port_hi, mac_rx.data} != listened_port);
            CNT_W'(OFS_PREAMBLE):     fail_now = (mac_rx.data != PREAMBLE_3);
            CNT_W'(OFS_PREAMBLE + 1): fail_now = (mac_rx.data != PREAMBLE_2);
            CNT_W'(OFS_PREAMBLE + 2): fail_now = (mac_rx.data != PREAMBLE_1);
            CNT_W'(OFS_PREAMBLE + 3): fail_now = (mac_rx.data != PREAMBLE_0);
            default:                  fail_now = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            hdr_fail <= 1'b0;
            msg_ok   <= 1'b0;
            body_wr  <= 1'b0;
        end else begin
            hdr_fail <= mac_rx.valid && fail_now;
            body_wr  <= mac_rx.valid && in_body;
            if (mac_rx.valid) begin
                if (mac_rx.sof) begin
                    msg_ok <= 1'b0;
                end else if (last_pay) begin
                    // last payload byte carries the checksum
                    msg_ok <= len_match && (mac_rx.data == csum);
                end
            end
        end
    end

    // ------------------------------
    // field capture and running sum
    // ------------------------------
    always_ff @(posedge clk) begin
        body_data <= mac_rx.data;
        if (mac_rx.valid) begin
            if (byte_idx >= CNT_W'(OFS_DST_IP) && byte_idx < CNT_W'(OFS_DST_IP + 3)) begin
                dst_ip_hi <= {dst_ip_hi[15:0], mac_rx.data};
            end
            case (byte_idx)
                CNT_W'(OFS_DST_PORT):    dst_port_hi    <= mac_rx.data;
                CNT_W'(OFS_UDP_LEN):     udp_len[15:8]  <= mac_rx.data;
                CNT_W'(OFS_UDP_LEN + 1): udp_len[7:0]   <= mac_rx.data;
                CNT_W'(OFS_MSG_TYPE): begin
                    hdr.msg_type <= mac_rx.data;
                    csum         <= mac_rx.data;
                end
                CNT_W'(OFS_SEQ): begin
                    hdr.seq_no <= mac_rx.data;
                    csum       <= csum + mac_rx.data;
                end
                CNT_W'(OFS_LEN): begin
                    hdr.total_len <= mac_rx.data;
                    csum          <= csum + mac_rx.data;
                end
                default: begin
                    if (in_body && !last_pay) begin
                        csum <= csum + mac_rx.data;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/helm_msg_buffer.sv ====
module helm_msg_buffer
    import helm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_b,
    input  logic              body_wr,
    input  logic [7:0]        body_data,
    input  mac_rx_t           mac_rx,
    input  logic              rd_en,
    input  logic [BUF_AW-1:0] rd_addr,
    output logic [7:0]        rd_data
);

    logic [7:0]        mem [2**BUF_AW];
    logic [BUF_AW-1:0] wr_addr;

    // body byte 0 always lands at address 0
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wr_addr <= '0;
        end else if (mac_rx.valid && mac_rx.sof) begin
            wr_addr <= '0;
        end else if (body_wr) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (body_wr) begin
            mem[wr_addr] <= body_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== verilog/helm_cmd_exec.sv ====
module helm_cmd_exec
    import helm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_b,
    input  logic              exec_start,
    input  logic              exec_byte,
    input  logic [7:0]        rd_data,
    input  logic [7:0]        usr_mem_rd_data,
    output logic              rd_en,
    output logic [BUF_AW-1:0] rd_addr,
    output usr_mem_req_t      usr_mem,
    output logic              exec_done
);

    logic              running;
    logic              is_byte;
    logic              rd_vld;
    logic [BUF_AW-1:0] rd_idx;
    cmd_word_u         cmd;
    logic              blk_wr;
    logic              blk_last;

    // block data runs from body byte 3 to data_len+2
    assign blk_wr   = (rd_idx >= BUF_AW'(3)) &&
                      (rd_idx < BUF_AW'(cmd.blk.data_len) + BUF_AW'(3));
    assign blk_last = (rd_idx >= BUF_AW'(3)) &&
                      (rd_idx >= BUF_AW'(cmd.blk.data_len) + BUF_AW'(2));

    // ------------------------------
    // buffer read side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            running <= 1'b0;
            rd_en   <= 1'b0;
            rd_vld  <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_idx <= rd_addr;
            if (exec_start) begin
                running <= 1'b1;
                is_byte <= exec_byte;
                rd_en   <= 1'b1;
                rd_addr <= '0;
            end else if (running) begin
                rd_addr <= rd_addr + 1'b1;
                if (exec_done) begin
                    running <= 1'b0;
                    rd_en   <= 1'b0;
                end
            end
        end
    end

    // ------------------------------
    // command decode and user memory
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            usr_mem.cs    <= 1'b0;
            usr_mem.rd_en <= 1'b0;
            usr_mem.wr_en <= 1'b0;
            exec_done     <= 1'b0;
        end else begin
            usr_mem.cs    <= 1'b0;
            usr_mem.rd_en <= 1'b0;
            usr_mem.wr_en <= 1'b0;
            exec_done     <= 1'b0;
            if (running && rd_vld && !exec_done) begin
                if (rd_idx < BUF_AW'(4)) begin
                    cmd[8*(3-rd_idx[1:0]) +: 8] <= rd_data;
                end
                if (is_byte) begin
                    if (rd_idx == BUF_AW'(1)) begin
                        // fetch the old byte, it returns with the mask
                        usr_mem.cs     <= 1'b1;
                        usr_mem.rd_en  <= 1'b1;
                        usr_mem.page   <= cmd.byt.page;
                        usr_mem.offset <= rd_data;
                    end else if (rd_idx == BUF_AW'(3)) begin
                        usr_mem.cs      <= 1'b1;
                        usr_mem.wr_en   <= 1'b1;
                        usr_mem.wr_data <= (cmd.byt.value & rd_data) |
                                           (usr_mem_rd_data & ~rd_data);
                        exec_done       <= 1'b1;
                    end
                end else begin
                    if (blk_wr) begin
                        usr_mem.cs      <= 1'b1;
                        usr_mem.wr_en   <= 1'b1;
                        usr_mem.page    <= cmd.blk.page;
                        usr_mem.offset  <= cmd.blk.offset + 8'(rd_idx - BUF_AW'(3));
                        usr_mem.wr_data <= rd_data;
                    end
                    exec_done <= blk_last;
                end
            end
        end
    end

endmodule

// ==== verilog/helm_rx_fsm.sv ====
module helm_rx_fsm
    import helm_pkg::*;
(
    input  logic     clk,
    input  logic     rst_b,
    input  mac_rx_t  mac_rx,
    input  logic     hdr_fail,
    input  logic     msg_ok,
    input  msg_hdr_t hdr,
    input  logic     exec_done,
    output logic     exec_start,
    output logic     exec_byte,
    output logic     busy,
    output logic     msg_dropped
);

    logic [2:0] state;
    logic       known_type;
    logic       beat_eof;

    assign beat_eof   = mac_rx.valid && mac_rx.eof;
    assign known_type = (hdr.msg_type == MSG_BLK_WRITE) || (hdr.msg_type == MSG_BYTE_WRITE);

    // command leaves in the cycle after eof
    assign exec_start = (state == ST_DONE) && msg_ok && !hdr_fail && known_type;
    assign exec_byte  = (hdr.msg_type == MSG_BYTE_WRITE);
    assign busy       = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            state       <= ST_IDLE;
            msg_dropped <= 1'b0;
        end else begin
            msg_dropped <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (mac_rx.valid && mac_rx.sof) begin
                        state <= mac_rx.eof ? ST_DONE : ST_RECV;
                    end
                end
                ST_RECV: begin
                    if (hdr_fail && beat_eof) begin
                        msg_dropped <= 1'b1;
                        state       <= ST_IDLE;
                    end else if (hdr_fail) begin
                        state <= ST_DROP;
                    end else if (beat_eof) begin
                        state <= ST_DONE;
                    end
                end
                // rest of a rejected frame
                ST_DROP: begin
                    if (beat_eof) begin
                        msg_dropped <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_DONE: begin
                    if (exec_start) begin
                        state <= ST_EXEC;
                    end else begin
                        msg_dropped <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_EXEC: begin
                    if (exec_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/helm_msg_recv.sv ====
module helm_msg_recv
    import helm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_b,
    input  mac_rx_t      mac_rx,
    input  logic [31:0]  listened_ip1,
    input  logic [31:0]  listened_ip2,
    input  logic [15:0]  listened_port,
    output usr_mem_req_t usr_mem,
    input  logic [7:0]   usr_mem_rd_data,
    output logic         busy,
    output logic         msg_dropped
);

    logic [CNT_W-1:0]  byte_idx;
    logic              hdr_fail;
    logic              msg_ok;
    msg_hdr_t          hdr;
    logic              body_wr;
    logic [7:0]        body_data;
    logic              exec_start;
    logic              exec_byte;
    logic              exec_done;
    logic              rd_en;
    logic [BUF_AW-1:0] rd_addr;
    logic [7:0]        rd_data;

    // ------------------------------
    // receive path
    // ------------------------------
    helm_byte_counter i_helm_byte_counter (
        .clk      (clk),
        .rst_b    (rst_b),
        .mac_rx   (mac_rx),
        .byte_idx (byte_idx)
    );

    helm_frame_check i_helm_frame_check (
        .clk           (clk),
        .rst_b         (rst_b),
        .mac_rx        (mac_rx),
        .byte_idx      (byte_idx),
        .listened_ip1  (listened_ip1),
        .listened_ip2  (listened_ip2),
        .listened_port (listened_port),
        .hdr_fail      (hdr_fail),
        .msg_ok        (msg_ok),
        .hdr           (hdr),
        .body_wr       (body_wr),
        .body_data     (body_data)
    );

    helm_msg_buffer i_helm_msg_buffer (
        .clk       (clk),
        .rst_b     (rst_b),
        .body_wr   (body_wr),
        .body_data (body_data),
        .mac_rx    (mac_rx),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // ------------------------------
    // control and execution
    // ------------------------------
    helm_rx_fsm i_helm_rx_fsm (
        .clk         (clk),
        .rst_b       (rst_b),
        .mac_rx      (mac_rx),
        .hdr_fail    (hdr_fail),
        .msg_ok      (msg_ok),
        .hdr         (hdr),
        .exec_done   (exec_done),
        .exec_start  (exec_start),
        .exec_byte   (exec_byte),
        .busy        (busy),
        .msg_dropped (msg_dropped)
    );

    helm_cmd_exec i_helm_cmd_exec (
        .clk             (clk),
        .rst_b           (rst_b),
        .exec_start      (exec_start),
        .exec_byte       (exec_byte),
        .rd_data         (rd_data),
        .usr_mem_rd_data (usr_mem_rd_data),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .usr_mem         (usr_mem),
        .exec_done       (exec_done)
    );

endmodule

// ==== dv/tb_helm_msg_recv.sv ====
module tb_helm_msg_recv
    import helm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic         clk = 1'b0;
    logic         rst_b;
    mac_rx_t      mac_rx;
    logic [31:0]  listened_ip1;
    logic [31:0]  listened_ip2;
    logic [15:0]  listened_port;
    usr_mem_req_t usr_mem;
    logic [7:0]   usr_mem_rd_data = 8'h00;
    logic         busy;
    logic         msg_dropped;

    logic [7:0]   umem [65536];
    logic         rd_pending = 1'b0;
    logic [15:0]  rd_word_addr = 16'h0000;
    logic [7:0]   frame_q [$];
    logic [7:0]   body_q [$];
    logic [7:0]   data_q [$];
    logic         strobe;
    logic         seen_sof = 1'b0;
    int           wr_count = 0;
    int           drop_count = 0;
    string        test_name = "reset";

    helm_msg_recv i_helm_msg_recv (
        .clk             (clk),
        .rst_b           (rst_b),
        .mac_rx          (mac_rx),
        .listened_ip1    (listened_ip1),
        .listened_ip2    (listened_ip2),
        .listened_port   (listened_port),
        .usr_mem         (usr_mem),
        .usr_mem_rd_data (usr_mem_rd_data),
        .busy            (busy),
        .msg_dropped     (msg_dropped)
    );

    always #5 clk = ~clk;

    assign strobe = usr_mem.cs | usr_mem.rd_en | usr_mem.wr_en;

    // ------------------------------
    // user memory model
    // ------------------------------
    initial begin
        int a;
        for (a = 0; a < 65536; a++) begin
            umem[a] = a[15:8] ^ a[7:0] ^ 8'h3c;
        end
    end

    // read data returns one cycle after the request
    always @(negedge clk) begin
        if (rd_pending) begin
            usr_mem_rd_data <= umem[rd_word_addr];
        end
        rd_pending   <= usr_mem.cs && usr_mem.rd_en;
        rd_word_addr <= {usr_mem.page, usr_mem.offset};
        if (usr_mem.cs && usr_mem.wr_en) begin
            umem[{usr_mem.page, usr_mem.offset}] = usr_mem.wr_data;
        end
    end

    // ------------------------------
    // monitors
    // ------------------------------
    always @(posedge clk) begin
        if (mac_rx.valid && mac_rx.sof) begin
            seen_sof <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst_b) begin
            if (!seen_sof) begin
                assert (!busy && !msg_dropped && !strobe) else begin
                    $display("outputs active after reset before the first frame");
                    stop_on_error();
                end
            end
            assert (busy || !strobe) else begin
                $display("user memory strobe seen while busy is low (%s)", test_name);
                stop_on_error();
            end
            if (usr_mem.cs && usr_mem.wr_en) begin
                wr_count <= wr_count + 1;
            end
            if (msg_dropped) begin
                drop_count <= drop_count + 1;
            end
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic make_block_body(input logic [7:0] page, input logic [7:0] offset,
                                   input int len);
        int i;
        data_q.delete();
        body_q.delete();
        body_q.push_back(page);
        body_q.push_back(offset);
        body_q.push_back(8'(len));
        for (i = 0; i < len; i++) begin
            data_q.push_back(8'($urandom));
            body_q.push_back(data_q[i]);
        end
    endtask

    // ethernet, ip and udp header, then preamble, message header, body, checksum
    task automatic build_frame(input logic [31:0] dst_ip, input logic [15:0] dst_port,
                               input logic [7:0] msg_type);
        int          i;
        logic [7:0]  seq;
        logic [7:0]  sum;
        logic [15:0] udp_len;
        seq     = 8'($urandom);
        udp_len = 16'(UDP_HDR_LEN + 8 + body_q.size());
        frame_q.delete();
        for (i = 0; i < OFS_PREAMBLE; i++) begin
            frame_q.push_back(8'($urandom));
        end
        frame_q[OFS_ETYPE_HI] = ETYPE_IPV4_HI;
        frame_q[OFS_ETYPE_LO] = ETYPE_IPV4_LO;
        frame_q[OFS_PROTO]    = PROTO_UDP;
        for (i = 0; i < 4; i++) begin
            frame_q[OFS_DST_IP + i] = dst_ip[8*(3-i) +: 8];
        end
        frame_q[OFS_DST_PORT]    = dst_port[15:8];
        frame_q[OFS_DST_PORT + 1] = dst_port[7:0];
        frame_q[OFS_UDP_LEN]     = udp_len[15:8];
        frame_q[OFS_UDP_LEN + 1] = udp_len[7:0];
        frame_q.push_back(PREAMBLE_3);
        frame_q.push_back(PREAMBLE_2);
        frame_q.push_back(PREAMBLE_1);
        frame_q.push_back(PREAMBLE_0);
        frame_q.push_back(msg_type);
        frame_q.push_back(seq);
        frame_q.push_back(8'(body_q.size()));
        sum = msg_type + seq + 8'(body_q.size());
        for (i = 0; i < body_q.size(); i++) begin
            frame_q.push_back(body_q[i]);
            sum = sum + body_q[i];
        end
        frame_q.push_back(sum);
    endtask

    task automatic build_block_frame(input logic [31:0] dst_ip, input logic [15:0] dst_port);
        make_block_body(8'($urandom), 8'($urandom), $urandom_range(4, 1));
        build_frame(dst_ip, dst_port, MSG_BLK_WRITE);
    endtask

    // random idle gaps between beats
    task automatic send_frame();
        int i;
        int last;
        last = frame_q.size() - 1;
        for (i = 0; i <= last; i++) begin
            repeat ($urandom_range(2, 0)) begin
                @(negedge clk);
                mac_rx = '0;
            end
            @(negedge clk);
            mac_rx.valid = 1'b1;
            mac_rx.sof   = (i == 0);
            mac_rx.eof   = (i == last);
            mac_rx.data  = frame_q[i];
        end
        @(negedge clk);
        mac_rx = '0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("timeout in %s: busy did not fall within 1000 cycles", test_name);
            stop_on_error();
        end else begin
            // let the monitor counts settle
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic send_good(input int exp_writes);
        int wr0;
        int drop0;
        wr0   = wr_count;
        drop0 = drop_count;
        send_frame();
        wait_idle();
        check_value("user memory writes", exp_writes, wr_count - wr0);
        check_value("drop pulses", 0, drop_count - drop0);
    endtask

    task automatic expect_drop();
        int wr0;
        int drop0;
        wr0   = wr_count;
        drop0 = drop_count;
        send_frame();
        wait_idle();
        check_value("drop pulses", 1, drop_count - drop0);
        check_value("user memory writes", 0, wr_count - wr0);
    endtask

    task automatic block_write_test(input logic [31:0] dst_ip);
        logic [7:0] page;
        logic [7:0] offset;
        int         i;
        page   = 8'($urandom);
        offset = 8'($urandom);
        make_block_body(page, offset, $urandom_range(16, 1));
        build_frame(dst_ip, listened_port, MSG_BLK_WRITE);
        send_good(data_q.size());
        for (i = 0; i < data_q.size(); i++) begin
            check_value("stored byte", int'(data_q[i]), int'(umem[{page, 8'(offset + i)}]));
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [7:0] page;
        logic [7:0] offset;
        logic [7:0] old;
        logic [7:0] value;
        logic [7:0] mask;
        logic [7:0] expect_byte;
        int         n;
        void'($urandom(9191));
        rst_b         = 1'b0;
        mac_rx        = '0;
        listened_ip1  = 32'hc0a8_0114;
        listened_ip2  = 32'hc0a8_01c8;
        listened_port = 16'h1388;
        repeat (5) @(negedge clk);
        rst_b = 1'b1;
        repeat (10) @(negedge clk);

        test_name = "block_write";
        for (n = 0; n < 3; n++) begin
            block_write_test(listened_ip1);
        end

        // old content comes in through a one-byte block write
        test_name = "byte_write";
        for (n = 0; n < 3; n++) begin
            page   = 8'($urandom);
            offset = 8'($urandom);
            make_block_body(page, offset, 1);
            old = data_q[0];
            build_frame(listened_ip1, listened_port, MSG_BLK_WRITE);
            send_good(1);
            value = 8'($urandom);
            mask  = 8'($urandom);
            body_q.delete();
            body_q.push_back(page);
            body_q.push_back(offset);
            body_q.push_back(value);
            body_q.push_back(mask);
            build_frame(listened_ip2, listened_port, MSG_BYTE_WRITE);
            send_good(1);
            expect_byte = (value & mask) | (old & ~mask);
            check_value("masked byte", int'(expect_byte), int'(umem[{page, offset}]));
        end

        test_name = "bad_ethertype";
        build_block_frame(listened_ip1, listened_port);
        frame_q[OFS_ETYPE_LO] = 8'h06;
        expect_drop();

        test_name = "bad_protocol";
        build_block_frame(listened_ip1, listened_port);
        frame_q[OFS_PROTO] = 8'h06;
        expect_drop();

        test_name = "bad_dst_ip";
        build_block_frame(listened_ip1 ^ 32'h0000_0100, listened_port);
        expect_drop();

        test_name = "bad_dst_port";
        build_block_frame(listened_ip2, listened_port ^ 16'h0001);
        expect_drop();

        test_name = "bad_preamble";
        build_block_frame(listened_ip1, listened_port);
        frame_q[OFS_PREAMBLE + 2] = frame_q[OFS_PREAMBLE + 2] ^ 8'h01;
        expect_drop();

        test_name = "bad_checksum";
        build_block_frame(listened_ip1, listened_port);
        frame_q[frame_q.size() - 1] = frame_q[frame_q.size() - 1] ^ 8'h01;
        expect_drop();

        // length byte and checksum raised together so only the length is off
        test_name = "bad_length";
        build_block_frame(listened_ip1, listened_port);
        frame_q[OFS_LEN] = frame_q[OFS_LEN] + 8'd1;
        frame_q[frame_q.size() - 1] = frame_q[frame_q.size() - 1] + 8'd1;
        expect_drop();

        test_name = "unknown_type";
        make_block_body(8'($urandom), 8'($urandom), 2);
        build_frame(listened_ip1, listened_port, 8'h5a);
        expect_drop();

        test_name = "block_write_after_drops";
        block_write_test(listened_ip2);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/helm_pkg.sv
verilog/helm_byte_counter.sv
verilog/helm_frame_check.sv
verilog/helm_msg_buffer.sv
verilog/helm_cmd_exec.sv
verilog/helm_rx_fsm.sv
verilog/helm_msg_recv.sv
dv/tb_helm_msg_recv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_helm_msg_recv
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
